/* verification/cordic_stim.txt */
# columns: name mode x_in y_in z_in exp_x exp_y exp_z
# mode 0 rotation, 1 circular vectoring, 2 linear vectoring; all values Q16.16 integers
rot_zero      0       0        0        0    65536       0       0
rot_half      0       0        0    32768    57513   31420       0
rot_neg       0       0        0   -45875    50125  -42219       0
rot_edge_neg  0       0        0   -51446    46359  -46323       0
rot_q1        0       0        0    78643    23748   61082       0
rot_q2        0       0        0   183501   -61749   21954       0
rot_q3        0       0        0   229376   -61372  -22989       0
rot_q4        0       0        0   294912   -13815  -64063       0
rot_q4_top    0       0        0   347341    36332  -54543       0
rot_wrap_9    0       0        0   589824   -59712   27009       0
rot_wrap_m7   0       0        0  -458752    49408  -43056       0
rot_wrap_20   0       0        0  1310720    26744   59831       0
rot_wrap_m13  0       0        0  -851968    59470  -27536       0
vec_diag      1   65536    65536        0    92682       0   51472
vec_3_m4      1  196608  -262144    16384   327680       0  -44387
vec_2_half    1  131072    32768   -65536   135106       0  -49481
vec_steep     1   32768    98304        0   103622       0   81857
vec_flat      1   98304        0    19661    98304       0   19661
lin_half      2  131072    65536        0   131072       0   32768
lin_neg       2   65536   -98304    16384    65536       0  -81920
lin_third     2  196608   131072   -32768   196608       0   10923
lin_neg_x     2 -131072   196608    65536  -131072       0  -32768

/* project.f */
hdl/cordic_pkg.sv
hdl/cordic_decode.sv
hdl/cordic_execute.sv
hdl/cordic_result.sv
hdl/cordic_top.sv
verification/cordic_sva.sv
verification/cordic_tb.sv

/* Bender.yml */
package:
  name: cordic

sources:
  - files:
      - hdl/cordic_pkg.sv
      - hdl/cordic_decode.sv
      - hdl/cordic_execute.sv
      - hdl/cordic_result.sv
      - hdl/cordic_top.sv
  - target: test
    files:
      - verification/cordic_sva.sv
      - verification/cordic_tb.sv

/* verification/cordic_tb.sv */
`timescale 1ns/1ps

module cordic_tb;
    import cordic_pkg::*;

    localparam int TOL        = 64;                // accepted error in LSB
    localparam int WAIT_LIMIT = 200;
    localparam int MAX_LINES  = 256;

    logic        clk;
    logic        rst;
    logic        start;
    cordic_job_t job;
    logic        busy;
    cordic_vec_t res;
    logic        valid;

    int          error_count;
    int          timeout_count;
    int          job_count;
    logic [31:0] lfsr;

    cordic_top #(
        .ITERATIONS (16)
    ) i_dut (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .job   (job),
        .busy  (busy),
        .res   (res),
        .valid (valid)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'ha3000000) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output int value);
        int i;
        value = 0;
        for (i = 0; i < n; i++) begin
            value = (value << 1) | int'(lfsr[0]);
            lfsr  = lfsr_next(lfsr);               // one step per bit
        end
    endtask

    // step to the next falling edge and flag any stray valid
    task automatic next_cycle();
        @(negedge clk);
        if (valid) begin
            $display("Error: valid pulse while no job was waiting for it");
            error_count++;
        end
    endtask

    task automatic check_field(input logic [127:0] name, input string field,
                               input int expected, input int actual);
        if ((actual - expected > TOL) || (expected - actual > TOL)) begin
            $display("Fail %0s %0s: expected %0d, actual %0d", name, field, expected, actual);
            error_count++;
        end
    endtask

    task automatic run_job(input logic [127:0] name, input cordic_job_t jb,
                           input cordic_vec_t expected);
        int   cycles;
        logic seen;
        seen  = 1'b0;
        start = 1'b1;
        job   = jb;
        next_cycle();
        if (!busy) begin
            $display("Error: busy did not rise after the start of %0s", name);
            error_count++;
        end
        job.mode = mode_vec_lin;                   // second start while busy must be dropped
        job.vec  = ~jb.vec;
        next_cycle();
        start  = 1'b0;
        job    = '0;
        cycles = 0;
        while (!seen && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            seen = valid;
            cycles++;
        end
        if (!seen) begin
            $display("Timeout: no valid within %0d cycles for %0s", WAIT_LIMIT, name);
            timeout_count++;
        end else begin
            if (busy) begin
                $display("Error: busy still high in the valid cycle of %0s", name);
                error_count++;
            end
            check_field(name, "x", expected.x, res.x);
            check_field(name, "y", expected.y, res.y);
            check_field(name, "z", expected.z, res.z);
        end
    endtask

    initial begin
        int            fd;
        int            n;
        int            lines;
        int            gap;
        int            col [7];
        logic [1023:0] line_buf;
        logic [127:0]  name;
        cordic_job_t   jb;
        cordic_vec_t   expected;

        clk           = 1'b0;
        rst           = 1'b1;
        start         = 1'b0;
        job           = '0;
        lfsr          = 32'ha8e3b8ac;
        error_count   = 0;
        timeout_count = 0;
        job_count     = 0;

        repeat (8) @(negedge clk);
        rst = 1'b0;
        next_cycle();
        if (busy || valid || (res != '0)) begin
            $display("Fail reset: expected busy/valid/res 0/0/0, actual %0b/%0b/%0h",
                     busy, valid, res);
            error_count++;
        end

        fd = $fopen("verification/cordic_stim.txt", "r");
        if (fd == 0) begin
            $display("Error: cannot open the stim file");
            error_count++;
        end else begin
            lines = 0;
            while (!$feof(fd) && lines < MAX_LINES) begin
                lines++;
                line_buf = '0;
                n = $fgets(line_buf, fd);
                if (n > 0) begin
                    n = $sscanf(line_buf, "%s %d %d %d %d %d %d %d", name,
                                col[0], col[1], col[2], col[3], col[4], col[5], col[6]);
                    if (n == 8) begin              // comments and blank lines give fewer fields
                        jb.mode     = cordic_mode_t'(col[0]);
                        jb.vec.x    = col[1];
                        jb.vec.y    = col[2];
                        jb.vec.z    = col[3];
                        expected.x  = col[4];
                        expected.y  = col[5];
                        expected.z  = col[6];
                        draw_bits(3, gap);         // idle gap of 0 to 7 cycles
                        repeat (gap) next_cycle();
                        run_job(name, jb, expected);
                        job_count++;
                    end
                end
            end
            $fclose(fd);
        end
        repeat (32) next_cycle();

        if (job_count == 0) begin
            $display("Error: no jobs were read from the stim file");
            error_count++;
        end

        $display("jobs %0d, errors %0d, timeouts %0d, assertion failures %0d",
                 job_count, error_count, timeout_count, i_dut.i_sva.fail_count);
        if (error_count == 0 && timeout_count == 0 && i_dut.i_sva.fail_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* verification/cordic_sva.sv */
`timescale 1ns/1ps

module cordic_sva (
    input logic clk,
    input logic rst,
    input logic start,
    input logic busy,
    input logic valid
);
    import cordic_pkg::*;

    int   fail_count = 0;
    logic job_open;                                // accepted start still waiting for its valid

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            job_open <= 1'b0;
        end else if (start && !busy) begin
            job_open <= 1'b1;                      // a new job may open in the valid cycle
        end else if (valid) begin
            job_open <= 1'b0;
        end
    end

    valid_single: assert property (@(posedge clk) disable iff (rst) valid |=> !valid)
        else begin
            $error("valid stayed high for more than one cycle");
            fail_count++;
        end

    // decode is back in idle by the time valid is seen
    busy_dropped: assert property (@(posedge clk) disable iff (rst) valid |-> !busy)
        else begin
            $error("busy still high while valid is high");
            fail_count++;
        end

    valid_has_job: assert property (@(posedge clk) disable iff (rst) $rose(valid) |-> job_open)
        else begin
            $error("valid rose without an accepted start");
            fail_count++;
        end

endmodule

bind cordic_top cordic_sva i_sva (
    .clk   (clk),
    .rst   (rst),
    .start (start),
    .busy  (busy),
    .valid (valid)
);

/* hdl/cordic_top.sv */
`timescale 1ns/1ps

module cordic_top #(
    parameter int ITERATIONS = 16
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  cordic_pkg::cordic_job_t job,
    output logic                    busy,
    output cordic_pkg::cordic_vec_t res,
    output logic                    valid
);
    import cordic_pkg::*;

    logic         load;
    logic         done;
    cordic_vec_t  init;
    cordic_vec_t  vec;
    cordic_mode_t mode;                            // held for the whole job
    quad_t        quad;

    cordic_decode i_decode (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .job   (job),
        .busy  (busy),
        .load  (load),
        .init  (init),
        .mode  (mode),
        .quad  (quad),
        .done  (done)
    );

    cordic_execute #(
        .ITERATIONS (ITERATIONS)
    ) i_execute (
        .clk  (clk),
        .rst  (rst),
        .load (load),
        .init (init),
        .mode (mode),
        .done (done),
        .vec  (vec)
    );

    cordic_result i_result (
        .clk   (clk),
        .rst   (rst),
        .done  (done),
        .vec   (vec),
        .mode  (mode),
        .quad  (quad),
        .res   (res),
        .valid (valid)
    );

endmodule

/* hdl/cordic_result.sv */
`timescale 1ns/1ps

module cordic_result (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     done,
    input  cordic_pkg::cordic_vec_t  vec,
    input  cordic_pkg::cordic_mode_t mode,
    input  cordic_pkg::quad_t        quad,
    output cordic_pkg::cordic_vec_t  res,
    output logic                     valid
);
    import cordic_pkg::*;

    logic signed [2*$bits(fixed_t)-1:0] mag_prod;
    fixed_t                             abs_x;
    cordic_vec_t                        res_d;

    assign abs_x    = (vec.x < 0) ? -vec.x : vec.x;
    assign mag_prod = abs_x * K_INV_CIRC;           // remove the circular gain

    always_comb begin
        res_d = vec;
        case (mode)
            mode_rot_circ: begin
                // rotate the result back by the folded angle
                case (quad)
                    3'd1: begin
                        res_d.x = -vec.y;
                        res_d.y = vec.x;
                    end
                    3'd2, 3'd3: begin
                        res_d.x = -vec.x;
                        res_d.y = -vec.y;
                    end
                    3'd4: begin
                        res_d.x = vec.y;
                        res_d.y = -vec.x;
                    end
                    default: ;
                endcase
            end
            mode_vec_circ: res_d.x = fixed_t'(mag_prod >>> FRAC_BITS);
            default: ;                             // linear result is used as is
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            res   <= '0;
            valid <= 1'b0;
        end else begin
            valid <= done;
            if (done) begin
                res <= res_d;
            end
        end
    end

endmodule

/* hdl/cordic_execute.sv */
`timescale 1ns/1ps

module cordic_execute #(
    parameter int ITERATIONS = cordic_pkg::ITER_MAX
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     load,
    input  cordic_pkg::cordic_vec_t  init,
    input  cordic_pkg::cordic_mode_t mode,
    output logic                     done,
    output cordic_pkg::cordic_vec_t  vec
);
    import cordic_pkg::*;

    localparam int IW = $clog2(ITER_MAX);

    // atan(2^-i) in Q16.16
    localparam fixed_t ATAN_TAB [ITER_MAX] = '{
        32'sd51472, 32'sd30386, 32'sd16055, 32'sd8150,
        32'sd4091,  32'sd2047,  32'sd1024,  32'sd512,
        32'sd256,   32'sd128,   32'sd64,    32'sd32,
        32'sd16,    32'sd8,     32'sd4,     32'sd2
    };

    // 2^-i in Q16.16
    localparam fixed_t POW2_TAB [ITER_MAX] = '{
        32'sd65536, 32'sd32768, 32'sd16384, 32'sd8192,
        32'sd4096,  32'sd2048,  32'sd1024,  32'sd512,
        32'sd256,   32'sd128,   32'sd64,    32'sd32,
        32'sd16,    32'sd8,     32'sd4,     32'sd2
    };

    logic [IW-1:0] iter;                           // index of the next iteration
    logic [IW-1:0] idx;
    logic          running;
    logic          sigma;                          // 1 for a positive step
    cordic_vec_t   cur;
    cordic_vec_t   nxt;
    fixed_t        x_sh;
    fixed_t        y_sh;
    fixed_t        alpha;

    // iteration 0 works on the incoming vector in the load cycle
    assign cur = load ? init : vec;
    assign idx = load ? '0 : iter;

    always_comb begin
        if (mode == mode_rot_circ) begin
            sigma = (cur.z >= 0);                  // drive z to zero
        end else begin
            sigma = ((cur.y < 0) != (cur.x < 0));  // drive y to zero
        end
    end

    assign x_sh  = cur.x >>> idx;
    assign y_sh  = cur.y >>> idx;
    assign alpha = (mode == mode_vec_lin) ? POW2_TAB[idx] : ATAN_TAB[idx];

    always_comb begin
        if (mode == mode_vec_lin) begin
            nxt.x = cur.x;                         // linear keeps x
        end else begin
            nxt.x = sigma ? cur.x - y_sh : cur.x + y_sh;
        end
        nxt.y = sigma ? cur.y + x_sh : cur.y - x_sh;
        nxt.z = sigma ? cur.z - alpha : cur.z + alpha;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            iter    <= '0;
            running <= 1'b0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (load) begin
                iter    <= IW'(1);
                running <= (ITERATIONS > 1);
                done    <= (ITERATIONS == 1);
            end else if (running) begin
                iter <= iter + 1'b1;
                if (iter == ITERATIONS - 1) begin
                    running <= 1'b0;
                    done    <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load || running) begin
            vec <= nxt;
        end
    end

endmodule

/* hdl/cordic_decode.sv */
`timescale 1ns/1ps

module cordic_decode (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start,
    input  cordic_pkg::cordic_job_t  job,
    output logic                     busy,
    output logic                     load,
    output cordic_pkg::cordic_vec_t  init,
    output cordic_pkg::cordic_mode_t mode,
    output cordic_pkg::quad_t        quad,
    input  logic                     done
);
    import cordic_pkg::*;

    typedef enum logic [1:0] {idle, reduce, fold, run} state_t;

    state_t state;
    fixed_t ang;                                   // angle being reduced
    fixed_t ang_step;                              // angle after one 2pi step
    fixed_t fold_z;
    quad_t  fold_q;

    function automatic logic in_band(input fixed_t a);
        return (a >= -PI_4) && (a <= SEVEN_PI_4);
    endfunction

    assign busy     = (state != idle);
    assign ang_step = (ang < -PI_4) ? ang + TWO_PI : ang - TWO_PI;

    // fold [-pi/4, 7pi/4] down to [-pi/4, pi/4]
    always_comb begin
        if (ang > FIVE_PI_4) begin
            fold_z = ang - (TWO_PI - PI_2);
            fold_q = 3'd4;
        end else if (ang > PI) begin
            fold_z = ang - PI;
            fold_q = 3'd3;
        end else if (ang > THREE_PI_4) begin
            fold_z = ang - PI;
            fold_q = 3'd2;
        end else if (ang > PI_4) begin
            fold_z = ang - PI_2;
            fold_q = 3'd1;
        end else begin
            fold_z = ang;
            fold_q = 3'd0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= idle;
            load  <= 1'b0;
            mode  <= mode_rot_circ;
            quad  <= '0;
        end else begin
            load <= 1'b0;
            case (state)
                idle: begin
                    if (start) begin
                        mode <= job.mode;
                        quad <= '0;
                        if (job.mode == mode_rot_circ) begin
                            state <= in_band(job.vec.z) ? fold : reduce;
                        end else begin
                            load  <= 1'b1;         // vectoring loads straight away
                            state <= run;
                        end
                    end
                end
                reduce: begin
                    if (in_band(ang_step)) begin
                        state <= fold;
                    end
                end
                fold: begin
                    quad  <= fold_q;
                    load  <= 1'b1;
                    state <= run;
                end
                run: begin
                    if (done) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            idle: begin
                if (start) begin
                    ang  <= job.vec.z;
                    init <= job.vec;
                end
            end
            reduce: ang <= ang_step;
            fold: begin
                init.x <= K_INV_CIRC;              // pre-scaled so the output needs no gain fix
                init.y <= '0;
                init.z <= fold_z;
            end
            default: ;
        endcase
    end

endmodule

/* hdl/cordic_pkg.sv */
package cordic_pkg;

    // Q16.16 signed fixed point word
    typedef logic signed [31:0] fixed_t;

    localparam int FRAC_BITS = 16;
    localparam int ITER_MAX  = 16;                 // depth of the angle tables

    typedef logic [2:0] quad_t;                    // fold index 0 to 4

    typedef enum logic [1:0] {
        mode_rot_circ,                             // cos and sin of z
        mode_vec_circ,                             // magnitude and atan(y/x)
        mode_vec_lin                               // z + y/x
    } cordic_mode_t;

    typedef struct packed {
        fixed_t x;
        fixed_t y;
        fixed_t z;
    } cordic_vec_t;

    typedef struct packed {
        cordic_mode_t mode;
        cordic_vec_t  vec;
    } cordic_job_t;

    // angles in Q16.16 radians
    localparam fixed_t PI_4       = 32'sd51472;
    localparam fixed_t PI_2       = 32'sd102944;
    localparam fixed_t THREE_PI_4 = 32'sd154416;
    localparam fixed_t PI         = 32'sd205887;
    localparam fixed_t FIVE_PI_4  = 32'sd257359;
    localparam fixed_t SEVEN_PI_4 = 32'sd360303;
    localparam fixed_t TWO_PI     = 32'sd411775;

    // inverse of the circular gain, about 0.60725
    localparam fixed_t K_INV_CIRC = 32'sd39797;

endpackage
